//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_endpoint > sim.log 2>&1 \
    && ./obj_dir/Vtb_endpoint >> sim.log 2>&1 \
    || echo "sim failed" >> sim.log
if grep -q "sim failed" sim.log; then
    echo "FAIL, see sim.log"
    exit 1
fi
echo "PASS"
exit 0

//--- src/chiplet_types_pkg.sv
package chiplet_types_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes and identity
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_MSGS  = 4;
    localparam int MSG_IDX_W = $clog2(NUM_MSGS);
    localparam int BUF_WORDS = 128;
    localparam int BUF_AW    = 7;
    localparam int BUF_BYTES = BUF_WORDS * 4;

    localparam logic [3:0] NODE_ID = 4'd0;  // fixed source id.

    //////////////////////////////////////////////////////////////////////
    // host address map, byte addresses
    //////////////////////////////////////////////////////////////////////

    localparam logic [15:0] START_BASE    = 16'h0000;
    localparam logic [15:0] SEND_ADDR     = 16'h1004;
    localparam logic [15:0] RX_COUNT_ADDR = 16'h1008;
    localparam logic [15:0] TX_BUF_BASE   = 16'h2000;
    localparam logic [15:0] RX_BUF_BASE   = 16'h3000;

    // packetizer state codes
    localparam logic [2:0] PK_IDLE      = 3'd0;
    localparam logic [2:0] PK_RD_HDR    = 3'd1;
    localparam logic [2:0] PK_SEND_HEAD = 3'd2;
    localparam logic [2:0] PK_RD_WORD   = 3'd3;
    localparam logic [2:0] PK_SEND_BODY = 3'd4;

    //////////////////////////////////////////////////////////////////////
    // flits
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        HEAD = 2'd0,
        BODY = 2'd1,
        TAIL = 2'd2
    } flit_kind_t;

    typedef struct packed {
        flit_kind_t           kind;
        logic [3:0]           dest;
        logic [3:0]           src;
        logic [MSG_IDX_W-1:0] msg_id;
        logic [7:0]           length;    // body flits that follow.
        logic [13:0]          reserved;
    } head_flit_t;

    typedef struct packed {
        flit_kind_t  kind;
        logic [31:0] payload;
    } data_flit_t;

    // same 34 bits, routing view or raw payload view
    typedef union packed {
        head_flit_t head;
        data_flit_t data;
    } flit_t;

    //////////////////////////////////////////////////////////////////////
    // host bus and internal requests
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        ren;
        logic        wen;
        logic [15:0] addr;
        logic [31:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        rvalid;
        logic        error;
    } host_rsp_t;

    typedef struct packed {
        logic                 valid;
        logic [MSG_IDX_W-1:0] msg_id;
        logic [BUF_AW-1:0]    start;  // word address of the header.
    } send_req_t;

    typedef struct packed {
        logic              en;
        logic [BUF_AW-1:0] addr;
        logic [31:0]       data;
    } ram_wr_t;

    typedef struct packed {
        logic              en;
        logic [BUF_AW-1:0] addr;
    } ram_rd_t;

endpackage

//--- src/endpoint_top.sv
`timescale 1ns/1ps

module endpoint_top (
    input  logic                         clk,
    input  logic                         n_rst,
    input  chiplet_types_pkg::host_req_t host_req,
    output chiplet_types_pkg::host_rsp_t host_rsp,
    output chiplet_types_pkg::flit_t     tx_flit,
    output logic                         tx_valid,
    input  logic                         tx_ready,
    input  chiplet_types_pkg::flit_t     rx_flit,
    input  logic                         data_ready
);
    import chiplet_types_pkg::*;

    logic [NUM_MSGS-1:0]              trigger;
    logic [NUM_MSGS-1:0][BUF_AW-1:0]  start_addrs;
    logic                             take;
    send_req_t                        offer;
    ram_wr_t                          tx_wr;
    ram_rd_t                          tx_rd;
    logic [31:0]                      tx_rd_data;
    ram_wr_t                          rx_wr;
    ram_rd_t                          rx_rd;
    logic [31:0]                      rx_rd_data;
    logic [7:0]                       rx_msg_count;

    host_regs regs_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .host_req     (host_req),
        .rx_rd_data   (rx_rd_data),
        .rx_msg_count (rx_msg_count),
        .host_rsp     (host_rsp),
        .trigger      (trigger),
        .start_addrs  (start_addrs),
        .tx_wr        (tx_wr),
        .rx_rd        (rx_rd)
    );

    message_table msg_table (
        .clk         (clk),
        .n_rst       (n_rst),
        .trigger     (trigger),
        .start_addrs (start_addrs),
        .take        (take),
        .offer       (offer)
    );

    tx_packetizer packetizer (
        .clk      (clk),
        .n_rst    (n_rst),
        .offer    (offer),
        .rd_data  (tx_rd_data),
        .tx_ready (tx_ready),
        .take     (take),
        .tx_rd    (tx_rd),
        .tx_flit  (tx_flit),
        .tx_valid (tx_valid)
    );

    rx_collector collector (
        .clk          (clk),
        .n_rst        (n_rst),
        .data_ready   (data_ready),
        .rx_flit      (rx_flit),
        .rx_wr        (rx_wr),
        .rx_msg_count (rx_msg_count)
    );

    packet_ram tx_buf (
        .clk     (clk),
        .wr      (tx_wr),
        .rd      (tx_rd),
        .rd_data (tx_rd_data)
    );

    packet_ram rx_buf (
        .clk     (clk),
        .wr      (rx_wr),
        .rd      (rx_rd),
        .rd_data (rx_rd_data)
    );

endmodule

//--- src/host_regs.sv
`timescale 1ns/1ps

module host_regs (
    input  logic                                   clk,
    input  logic                                   n_rst,
    input  chiplet_types_pkg::host_req_t           host_req,
    input  logic [31:0]                            rx_rd_data,
    input  logic [7:0]                             rx_msg_count,
    output chiplet_types_pkg::host_rsp_t           host_rsp,
    output logic [chiplet_types_pkg::NUM_MSGS-1:0] trigger,
    output logic [chiplet_types_pkg::NUM_MSGS-1:0][chiplet_types_pkg::BUF_AW-1:0] start_addrs,
    output chiplet_types_pkg::ram_wr_t             tx_wr,
    output chiplet_types_pkg::ram_rd_t             rx_rd
);
    import chiplet_types_pkg::*;

    logic [15:0]          start_off;
    logic [15:0]          tx_off;
    logic [15:0]          rx_off;
    logic                 in_start;
    logic                 in_tx;
    logic                 in_rx;
    logic                 is_send;
    logic                 is_count;
    logic                 send_ok;
    logic [MSG_IDX_W-1:0] slot;
    logic                 err;
    logic [31:0]          rdata_mux;
    logic                 rvalid_q;
    logic                 rd_start_q;
    logic                 rd_count_q;
    logic                 rd_rx_q;
    logic [MSG_IDX_W-1:0] rd_slot_q;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    assign start_off = host_req.addr - START_BASE;
    assign tx_off    = host_req.addr - TX_BUF_BASE;
    assign rx_off    = host_req.addr - RX_BUF_BASE;

    assign in_start = start_off < 16'(NUM_MSGS * 4);
    assign in_tx    = tx_off < 16'(BUF_BYTES);
    assign in_rx    = rx_off < 16'(BUF_BYTES);
    assign is_send  = host_req.addr == SEND_ADDR;
    assign is_count = host_req.addr == RX_COUNT_ADDR;

    assign slot    = start_off[2 +: MSG_IDX_W];
    assign send_ok = host_req.wdata < 32'(NUM_MSGS);

    // buffer ports are word addressed.
    assign tx_wr = '{en: host_req.wen && in_tx, addr: tx_off[BUF_AW+1:2], data: host_req.wdata};
    assign rx_rd = '{en: host_req.ren && in_rx, addr: rx_off[BUF_AW+1:2]};

    always_comb begin
        trigger = '0;
        if (host_req.wen && is_send && send_ok) begin
            trigger[host_req.wdata[MSG_IDX_W-1:0]] = 1'b1;
        end
    end

    always_comb begin
        err = 1'b0;
        if (host_req.ren || host_req.wen) begin
            if (in_start) begin
                err = 1'b0;
            end else if (is_send) begin
                err = host_req.wen && !send_ok;  // a read just returns 0.
            end else if (is_count) begin
                err = host_req.wen;              // count is read only.
            end else if (in_tx) begin
                err = host_req.ren;
            end else if (in_rx) begin
                err = host_req.wen;
            end else begin
                err = 1'b1;                      // unmapped.
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registers and read return
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            start_addrs <= '0;
            rvalid_q    <= 1'b0;
            rd_start_q  <= 1'b0;
            rd_count_q  <= 1'b0;
            rd_rx_q     <= 1'b0;
            rd_slot_q   <= '0;
        end else begin
            if (host_req.wen && in_start) begin
                start_addrs[slot] <= host_req.wdata[BUF_AW+1:2];
            end
            rvalid_q   <= host_req.ren;
            rd_start_q <= host_req.ren && in_start;
            rd_count_q <= host_req.ren && is_count;
            rd_rx_q    <= host_req.ren && in_rx;
            rd_slot_q  <= slot;
        end
    end

    always_comb begin
        rdata_mux = '0;                  // error reads return 0.
        if (rd_rx_q) begin
            rdata_mux = rx_rd_data;
        end else if (rd_start_q) begin
            rdata_mux = 32'({start_addrs[rd_slot_q], 2'b00});
        end else if (rd_count_q) begin
            rdata_mux = 32'(rx_msg_count);
        end
    end

    assign host_rsp = '{rdata: rdata_mux, rvalid: rvalid_q, error: err};

    one_strobe_a: assert property (@(posedge clk) disable iff (!n_rst)
        !(host_req.ren && host_req.wen));

endmodule

//--- src/message_table.sv
`timescale 1ns/1ps

module message_table (
    input  logic                                   clk,
    input  logic                                   n_rst,
    input  logic [chiplet_types_pkg::NUM_MSGS-1:0] trigger,
    input  logic [chiplet_types_pkg::NUM_MSGS-1:0][chiplet_types_pkg::BUF_AW-1:0] start_addrs,
    input  logic                                   take,
    output chiplet_types_pkg::send_req_t           offer
);
    import chiplet_types_pkg::*;

    logic [NUM_MSGS-1:0]  pending;
    logic [NUM_MSGS-1:0]  clear;
    logic                 pick_valid;
    logic [MSG_IDX_W-1:0] pick_id;

    always_comb begin
        clear = '0;
        if (take) begin
            clear[offer.msg_id] = 1'b1;
        end
    end

    // lowest pending slot wins.
    always_comb begin
        pick_valid = 1'b0;
        pick_id    = '0;
        for (int i = NUM_MSGS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick_valid = 1'b1;
                pick_id    = MSG_IDX_W'(i);
            end
        end
    end

    // offer is refreshed each cycle until it is taken, so a lower slot
    // that arrives while the packetizer is busy still goes first
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending <= '0;
            offer   <= '0;
        end else begin
            pending <= (pending & ~clear) | trigger;
            if (take) begin
                offer.valid <= 1'b0;
            end else begin
                offer <= '{valid: pick_valid, msg_id: pick_id, start: start_addrs[pick_id]};
            end
        end
    end

    take_on_offer_a: assert property (@(posedge clk) disable iff (!n_rst)
        take |-> offer.valid);

endmodule

//--- src/packet_ram.sv
`timescale 1ns/1ps

module packet_ram (
    input  logic                       clk,
    input  chiplet_types_pkg::ram_wr_t wr,
    input  chiplet_types_pkg::ram_rd_t rd,
    output logic [31:0]                rd_data
);
    import chiplet_types_pkg::*;

    logic [31:0] mem [0:BUF_WORDS-1];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // one cycle read latency, output holds between reads.
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

//--- src/rx_collector.sv
`timescale 1ns/1ps

module rx_collector (
    input  logic                       clk,
    input  logic                       n_rst,
    input  logic                       data_ready,
    input  chiplet_types_pkg::flit_t   rx_flit,
    output chiplet_types_pkg::ram_wr_t rx_wr,
    output logic [7:0]                 rx_msg_count
);
    import chiplet_types_pkg::*;

    logic [BUF_AW-1:0] wr_ptr;
    logic              msg_open;
    logic              is_head;
    logic              is_tail;
    logic              msg_done;

    assign is_head  = rx_flit.head.kind == HEAD;
    assign is_tail  = rx_flit.head.kind == TAIL;
    assign msg_done = data_ready && (is_tail || (is_head && rx_flit.head.length == 8'd0));

    // every flit is stored raw, head fields included.
    assign rx_wr = '{en: data_ready, addr: wr_ptr, data: rx_flit.data.payload};

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr       <= '0;
            msg_open     <= 1'b0;
            rx_msg_count <= '0;
        end else begin
            if (data_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (is_head) begin
                    msg_open <= rx_flit.head.length != 8'd0;
                end else if (is_tail) begin
                    msg_open <= 1'b0;
                end
            end
            if (msg_done) begin
                rx_msg_count <= rx_msg_count + 8'd1;
            end
        end
    end

    body_in_msg_a: assert property (@(posedge clk) disable iff (!n_rst)
        data_ready && !is_head |-> msg_open);

endmodule

//--- src/tx_packetizer.sv
`timescale 1ns/1ps

module tx_packetizer (
    input  logic                         clk,
    input  logic                         n_rst,
    input  chiplet_types_pkg::send_req_t offer,
    input  logic [31:0]                  rd_data,
    input  logic                         tx_ready,
    output logic                         take,
    output chiplet_types_pkg::ram_rd_t   tx_rd,
    output chiplet_types_pkg::flit_t     tx_flit,
    output logic                         tx_valid
);
    import chiplet_types_pkg::*;

    logic [2:0]           state;
    logic [7:0]           remaining;   // body flits not yet fetched.
    logic [BUF_AW-1:0]    ptr;
    logic [MSG_IDX_W-1:0] msg_id;
    logic                 sent;
    logic                 sending;

    assign sent    = tx_valid && tx_ready;
    assign sending = (state == PK_SEND_HEAD) || (state == PK_SEND_BODY);
    assign take    = (state == PK_IDLE) && offer.valid;

    //////////////////////////////////////////////////////////////////////
    // buffer reads
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        tx_rd.en   = 1'b0;
        tx_rd.addr = ptr + 1'b1;                 // wraps at BUF_WORDS.
        if (state == PK_IDLE) begin
            tx_rd.en   = offer.valid;
            tx_rd.addr = offer.start;            // header word.
        end else if (sending) begin
            tx_rd.en = sent && (remaining != 8'd0);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state     <= PK_IDLE;
            tx_valid  <= 1'b0;
            remaining <= '0;
        end else begin
            case (state)
                PK_IDLE: begin
                    if (offer.valid) begin
                        state <= PK_RD_HDR;
                    end
                end
                PK_RD_HDR: begin
                    remaining <= rd_data[15:8];
                    tx_valid  <= 1'b1;
                    state     <= PK_SEND_HEAD;
                end
                PK_SEND_HEAD, PK_SEND_BODY: begin
                    if (sent) begin
                        tx_valid <= 1'b0;
                        if (remaining != 8'd0) begin
                            remaining <= remaining - 8'd1;
                            state     <= PK_RD_WORD;
                        end else begin
                            state <= PK_IDLE;
                        end
                    end
                end
                PK_RD_WORD: begin
                    tx_valid <= 1'b1;
                    state    <= PK_SEND_BODY;
                end
                default: state <= PK_IDLE;
            endcase
        end
    end

    // flit and address registers load only while tx_valid is low.
    always_ff @(posedge clk) begin
        if (take) begin
            msg_id <= offer.msg_id;
        end
        if (tx_rd.en) begin
            ptr <= tx_rd.addr;
        end
        if (state == PK_RD_HDR) begin
            tx_flit.head <= '{kind: HEAD, dest: rd_data[3:0], src: NODE_ID, msg_id: msg_id,
                              length: rd_data[15:8], reserved: '0};
        end else if (state == PK_RD_WORD) begin
            tx_flit.data <= '{kind: (remaining == 8'd0) ? TAIL : BODY, payload: rd_data};
        end
    end

    flit_hold_a: assert property (@(posedge clk) disable iff (!n_rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_flit));

endmodule

//--- tb.f
+incdir+tests
src/chiplet_types_pkg.sv
src/host_regs.sv
src/message_table.sv
src/packet_ram.sv
src/tx_packetizer.sv
src/rx_collector.sv
src/endpoint_top.sv
tests/tb_endpoint.sv

//--- tests/tb_endpoint_checks.svh
`ifndef TB_ENDPOINT_CHECKS_SVH
`define TB_ENDPOINT_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// random numbers and reference model
//////////////////////////////////////////////////////////////////////

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// flit number idx of the message stored at start where idx 0 is the head.
function automatic flit_t expected_flit(input logic [31:0] img [0:BUF_WORDS-1],
                                        input logic [MSG_IDX_W-1:0] slot,
                                        input logic [BUF_AW-1:0] start,
                                        input int idx);
    flit_t             f;
    logic [31:0]       hdr;
    logic [7:0]        len;
    logic [BUF_AW-1:0] waddr;
    hdr   = img[start];
    len   = hdr[15:8];
    waddr = start + BUF_AW'(idx);  // wraps at the buffer end.
    if (idx == 0) begin
        f.head = '{kind: HEAD, dest: hdr[3:0], src: NODE_ID, msg_id: slot,
                   length: len, reserved: '0};
    end else begin
        f.data = '{kind: (idx == int'(len)) ? TAIL : BODY, payload: img[waddr]};
    end
    return f;
endfunction

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
        $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_rsp(input string name, input host_rsp_t got, input host_rsp_t exp);
    if (got !== exp) begin
        $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_count(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

`endif

//--- tests/tb_endpoint.sv
`timescale 1ns/1ps

module tb_endpoint;
    import chiplet_types_pkg::*;

    localparam logic [31:0] SEED = 32'h312c_3229;
    localparam int WAIT_LIMIT   = 1000;
    localparam int READY_OPEN   = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_HOLD   = 2;

    logic        clk = 1'b0;
    logic        n_rst;
    host_req_t   host_req;
    host_rsp_t   host_rsp;
    flit_t       tx_flit;
    logic        tx_valid;
    logic        tx_ready;
    flit_t       rx_flit;
    logic        data_ready;

    logic [31:0] rnd_state;
    logic [31:0] tx_shadow [0:BUF_WORDS-1];  // what the host wrote to the tx buffer.
    flit_t       exp_q [$];
    logic [31:0] rx_words [$];
    int          ready_mode = READY_OPEN;

    endpoint_top dut_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .tx_flit    (tx_flit),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_flit    (rx_flit),
        .data_ready (data_ready)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_endpoint_checks.svh"

    function automatic logic [31:0] next_rand();
        rnd_state = lcg_next(rnd_state);
        return rnd_state;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // host bus access
    //////////////////////////////////////////////////////////////////////

    task automatic write_word(input logic [15:0] addr, input logic [31:0] data, input logic err);
        @(negedge clk);
        host_req = '{ren: 1'b0, wen: 1'b1, addr: addr, wdata: data};
        @(negedge clk);
        check_rsp("host_rsp", host_rsp, '{rdata: 32'h0, rvalid: 1'b0, error: err});
        host_req = '0;
    endtask

    task automatic read_expect(input logic [15:0] addr, input logic [31:0] data, input logic err);
        @(negedge clk);
        host_req = '{ren: 1'b1, wen: 1'b0, addr: addr, wdata: 32'h0};
        @(negedge clk);
        check_rsp("host_rsp", host_rsp, '{rdata: data, rvalid: 1'b1, error: err});
        host_req = '0;
    endtask

    // header word with len body words behind it, then the slot's start register.
    task automatic load_message(input int slot, input logic [BUF_AW-1:0] start, input int len);
        logic [31:0]       word;
        logic [BUF_AW-1:0] addr;
        for (int k = 0; k <= len; k++) begin
            addr = start + BUF_AW'(k);
            word = next_rand();
            if (k == 0) begin
                word[15:8] = 8'(len);
            end
            write_word(TX_BUF_BASE + 16'({addr, 2'b00}), word, 1'b0);
            tx_shadow[addr] = word;
        end
        write_word(START_BASE + 16'(slot * 4), 32'({start, 2'b00}), 1'b0);
    endtask

    task automatic queue_message(input int slot, input logic [BUF_AW-1:0] start);
        int len;
        len = int'(tx_shadow[start][15:8]);
        for (int i = 0; i <= len; i++) begin
            exp_q.push_back(expected_flit(tx_shadow, MSG_IDX_W'(slot), start, i));
        end
    endtask

    task automatic drain_flits();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout, %0d flits never left the endpoint", exp_q.size());
            abort_run();
        end
        repeat (8) @(negedge clk);  // room for a stray extra flit.
    endtask

    task automatic wait_tx_valid();
        int n;
        n = 0;
        while (!tx_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!tx_valid) begin
            $display("timeout, the packetizer never raised tx_valid");
            abort_run();
        end
    endtask

    task automatic inject_rx_message(input int len);
        flit_t       f;
        logic [31:0] r;
        r = next_rand();
        f.head = '{kind: HEAD, dest: r[3:0], src: r[7:4], msg_id: r[9:8],
                   length: 8'(len), reserved: '0};
        for (int k = 0; k <= len; k++) begin
            if (k == 0) begin
                rx_words.push_back({f.head.dest, f.head.src, f.head.msg_id,
                                    f.head.length, f.head.reserved});
            end else begin
                f.data = '{kind: (k == len) ? TAIL : BODY, payload: next_rand()};
                rx_words.push_back(f.data.payload);
            end
            @(negedge clk);
            rx_flit    = f;
            data_ready = 1'b1;
            @(negedge clk);
            data_ready = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // switch side ready generation and flit compare
    //////////////////////////////////////////////////////////////////////

    initial begin : flit_checker
        logic [31:0] ready_state;
        flit_t       exp;
        ready_state = lcg_next(SEED);
        tx_ready    = 1'b1;
        forever begin
            @(negedge clk);
            ready_state = lcg_next(ready_state);
            case (ready_mode)
                READY_RANDOM: tx_ready = ready_state[31] | ready_state[30];
                READY_HOLD:   tx_ready = 1'b0;
                default:      tx_ready = 1'b1;
            endcase
            if (tx_valid && tx_ready) begin  // transfers at the next edge.
                if (exp_q.size() == 0) begin
                    $display("flit 0x%h sent while no flit was expected", tx_flit);
                    abort_run();
                end else begin
                    exp = exp_q.pop_front();
                    check_flit("tx_flit", tx_flit, exp);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]       val;
        logic [BUF_AW-1:0] start;
        logic [BUF_AW-1:0] starts [0:NUM_MSGS-1];
        int                rx_msgs;
        n_rst      = 1'b0;
        host_req   = '0;
        rx_flit    = '0;
        data_ready = 1'b0;
        rnd_state  = SEED;
        rx_msgs    = 0;
        repeat (3) @(negedge clk);
        n_rst = 1'b1;

        read_expect(START_BASE + 16'h8, 32'h0, 1'b0);
        read_expect(RX_COUNT_ADDR, 32'h0, 1'b0);

        // one message from slot 2.
        val   = next_rand();
        start = val[6:0];
        load_message(2, start, int'(val[15:8]) % 7);
        queue_message(2, start);
        write_word(SEND_ADDR, 32'd2, 1'b0);
        drain_flits();

        // back pressure while the body wraps past the buffer end
        ready_mode = READY_RANDOM;
        load_message(2, 7'd124, 6);
        queue_message(2, 7'd124);
        write_word(SEND_ADDR, 32'd2, 1'b0);
        drain_flits();

        // lower slots overtake while the switch stalls.
        ready_mode = READY_HOLD;
        for (int s = 0; s < NUM_MSGS; s++) begin
            val       = next_rand();
            starts[s] = BUF_AW'(s * 32) + BUF_AW'(val[3:0]);
            load_message(s, starts[s], (s == 0) ? 0 : 1 + s);
        end
        queue_message(2, starts[2]);
        write_word(SEND_ADDR, 32'd2, 1'b0);
        wait_tx_valid();
        queue_message(0, starts[0]);
        queue_message(1, starts[1]);
        queue_message(3, starts[3]);
        write_word(SEND_ADDR, 32'd3, 1'b0);
        write_word(SEND_ADDR, 32'd1, 1'b0);
        write_word(SEND_ADDR, 32'd0, 1'b0);
        ready_mode = READY_OPEN;
        drain_flits();

        for (int s = 0; s < NUM_MSGS; s++) begin
            val = (next_rand() & 32'h1ff) | 32'h3;
            write_word(START_BASE + 16'(s * 4), val, 1'b0);
            read_expect(START_BASE + 16'(s * 4), val & ~32'h3, 1'b0);
        end

        write_word(SEND_ADDR, 32'd4, 1'b1);
        read_expect(TX_BUF_BASE + 16'h10, 32'h0, 1'b1);
        write_word(RX_BUF_BASE + 16'h20, next_rand(), 1'b1);
        write_word(RX_COUNT_ADDR, 32'h1, 1'b1);
        read_expect(16'h4000, 32'h0, 1'b1);
        write_word(16'h4000, next_rand(), 1'b1);
        repeat (8) @(negedge clk);  // a rejected send starts nothing.

        inject_rx_message(2);
        inject_rx_message(0);
        inject_rx_message(1);
        rx_msgs = 3;
        for (int i = 0; i < rx_words.size(); i++) begin
            read_expect(RX_BUF_BASE + 16'(i * 4), rx_words[i], 1'b0);
        end
        read_expect(RX_COUNT_ADDR, 32'(rx_msgs), 1'b0);
        check_count("rx_msg_count", dut_i.rx_msg_count, 8'(rx_msgs));

        $display("sim passed");
        $finish;
    end

endmodule
